// File: hw/keypad_pkg.sv
package keypad_pkg;

    // matrix geometry
    localparam int KP_ROWS = 4;
    localparam int KP_COLS = 4;

    // one key word, two views: scanner writes row/col, dispatcher reads flat index
    typedef union packed {
        struct packed {
            logic [1:0] row;                     // upper bits of the index
            logic [1:0] col;
        } rc;
        logic [3:0] idx;                         // row*4 + col
    } key_pos_u;

    // flat key positions that are not plain digits
    localparam logic [3:0] KEY_ADD  = 4'd3;
    localparam logic [3:0] KEY_SUB  = 4'd7;
    localparam logic [3:0] KEY_MUL  = 4'd11;
    localparam logic [3:0] KEY_EQ   = 4'd12;
    localparam logic [3:0] KEY_ZERO = 4'd13;     // digit 0 sits off the 3x3 grid
    localparam logic [3:0] KEY_CLR  = 4'd14;
    localparam logic [3:0] KEY_NEG  = 4'd15;

    // key classes seen by the dispatcher
    localparam logic [2:0] KC_DIGIT = 3'd0;
    localparam logic [2:0] KC_OP    = 3'd1;
    localparam logic [2:0] KC_EQ    = 3'd2;
    localparam logic [2:0] KC_CLR   = 3'd3;
    localparam logic [2:0] KC_NEG   = 3'd4;

    // scan and debounce timing
    localparam logic [2:0] SCAN_DWELL      = 3'd4; // cycles per column
    localparam logic [2:0] SYNC_STAGES     = 3'd2; // row synchronizer depth
    localparam logic [3:0] DEBOUNCE_CYCLES = 4'd8; // stable samples to accept

    // scanner FSM state codes
    localparam logic [2:0] ST_SCAN     = 3'd0;
    localparam logic [2:0] ST_SETTLE   = 3'd1;
    localparam logic [2:0] ST_DEBOUNCE = 3'd2;
    localparam logic [2:0] ST_REQUEST  = 3'd3;
    localparam logic [2:0] ST_RELEASE  = 3'd4;

endpackage

// File: hw/calc_pkg.sv
package calc_pkg;

    // pending operator code
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_ADD  = 2'd1,
        OP_SUB  = 2'd2,
        OP_MUL  = 2'd3
    } op_e;

    // datapath widths
    localparam int DATA_W  = 16;                 // result and operand width
    localparam int ENTRY_W = 14;                 // magnitude reg, holds 9999

    // symmetric saturation range
    localparam int signed SAT_MAX = 32767;
    localparam int signed SAT_MIN = -32767;

    // operand entry limit
    localparam int MAX_DIGITS = 4;

endpackage

// File: hw/keypad_scan.sv
`timescale 1ns/1ps

module keypad_scan (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic [keypad_pkg::KP_ROWS-1:0] row_in,   // active low, pulled up
    output logic [keypad_pkg::KP_COLS-1:0] col_out,  // one column low at a time
    output logic                           key_req,
    output keypad_pkg::key_pos_u           key_word,
    input  logic                           key_ack
);

    logic [2:0]                     state;
    logic [keypad_pkg::KP_ROWS-1:0] row_meta;        // sync stage 1
    logic [keypad_pkg::KP_ROWS-1:0] row_sync;        // sync stage 2
    logic [keypad_pkg::KP_ROWS-1:0] row_pat;         // pattern under debounce
    logic [1:0]                     col;             // driven column
    logic [2:0]                     dwell_cnt;
    logic [3:0]                     deb_cnt;         // stable samples so far
    logic                           rows_idle;
    logic                           pat_same;
    logic                           deb_done;

    // lowest pressed row wins, no rollover
    function automatic logic [1:0] lowest_row(input logic [keypad_pkg::KP_ROWS-1:0] rows);
        logic [1:0] r;
        r = 2'd0;
        for (int i = keypad_pkg::KP_ROWS - 1; i >= 0; i--) begin
            if (!rows[i]) r = 2'(i);             // last hit is the lowest index
        end
        return r;
    endfunction

    assign rows_idle = &row_sync;                // no key on this column
    assign pat_same  = (row_sync == row_pat);
    assign deb_done  = (state == keypad_pkg::ST_DEBOUNCE) && pat_same &&
                       (deb_cnt == keypad_pkg::DEBOUNCE_CYCLES - 4'd1);

    always_comb begin
        col_out      = '1;
        col_out[col] = 1'b0;                     // drive the active column low
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_meta <= '1;                      // idle rows read high
            row_sync <= '1;
        end else begin
            row_meta <= row_in;
            row_sync <= row_meta;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= keypad_pkg::ST_SETTLE;
            col       <= 2'd0;
            dwell_cnt <= 3'd0;
            deb_cnt   <= 4'd0;
            key_req   <= 1'b0;
        end else begin
            case (state)
                keypad_pkg::ST_SETTLE: begin
                    dwell_cnt <= dwell_cnt + 3'd1;   // wait out sync latency
                    if (dwell_cnt == keypad_pkg::SYNC_STAGES - 3'd1)
                        state <= keypad_pkg::ST_SCAN;
                end
                keypad_pkg::ST_SCAN: begin
                    if (!rows_idle) begin
                        state   <= keypad_pkg::ST_DEBOUNCE; // column stays put
                        deb_cnt <= 4'd1;                    // this sample counts
                    end else if (dwell_cnt == keypad_pkg::SCAN_DWELL - 3'd1) begin
                        col       <= col + 2'd1;            // 0,1,2,3 then wrap
                        dwell_cnt <= 3'd0;
                        state     <= keypad_pkg::ST_SETTLE;
                    end else begin
                        dwell_cnt <= dwell_cnt + 3'd1;
                    end
                end
                keypad_pkg::ST_DEBOUNCE: begin
                    if (!pat_same) begin
                        state     <= keypad_pkg::ST_SETTLE; // bounce, rescan
                        dwell_cnt <= 3'd0;
                    end else if (deb_done) begin
                        state   <= keypad_pkg::ST_REQUEST;
                        key_req <= 1'b1;
                    end else begin
                        deb_cnt <= deb_cnt + 4'd1;
                    end
                end
                keypad_pkg::ST_REQUEST: begin
                    if (key_ack)
                        state <= keypad_pkg::ST_RELEASE;
                end
                keypad_pkg::ST_RELEASE: begin
                    if (key_req) begin
                        if (rows_idle)
                            key_req <= 1'b0;        // drop only after key release
                    end else if (!key_ack) begin
                        state     <= keypad_pkg::ST_SETTLE; // handshake closed
                        dwell_cnt <= 3'd0;
                    end
                end
                default: state <= keypad_pkg::ST_SETTLE;
            endcase
        end
    end

    // payload, held from req rise until ack falls
    always_ff @(posedge clk) begin
        if (state == keypad_pkg::ST_SCAN && !rows_idle)
            row_pat <= row_sync;
        if (deb_done) begin
            key_word.rc.row <= lowest_row(row_pat);
            key_word.rc.col <= col;
        end
    end

endmodule

// File: hw/key_dispatch.sv
`timescale 1ns/1ps

module key_dispatch (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 key_req,
    input  keypad_pkg::key_pos_u key_word,
    output logic                 key_ack,
    output logic                 digit_stb,
    output logic [3:0]           digit,
    output logic                 neg_stb,
    output logic                 op_stb,
    output calc_pkg::op_e        op,
    output logic                 eq_stb,
    output logic                 clr_stb
);

    logic       fire;                            // first cycle of a request
    logic [2:0] kclass;

    function automatic logic [2:0] key_class(input logic [3:0] idx);
        case (idx)
            keypad_pkg::KEY_ADD,
            keypad_pkg::KEY_SUB,
            keypad_pkg::KEY_MUL: return keypad_pkg::KC_OP;
            keypad_pkg::KEY_EQ:  return keypad_pkg::KC_EQ;
            keypad_pkg::KEY_CLR: return keypad_pkg::KC_CLR;
            keypad_pkg::KEY_NEG: return keypad_pkg::KC_NEG;
            default:             return keypad_pkg::KC_DIGIT;
        endcase
    endfunction

    // 3x3 grid gives row*3 + col + 1, zero is the odd one out
    function automatic logic [3:0] digit_value(input logic [3:0] idx);
        if (idx == keypad_pkg::KEY_ZERO)
            return 4'd0;
        return {2'b00, idx[3:2]} * 4'd3 + {2'b00, idx[1:0]} + 4'd1;
    endfunction

    function automatic calc_pkg::op_e op_code(input logic [3:0] idx);
        case (idx)
            keypad_pkg::KEY_ADD: return calc_pkg::OP_ADD;
            keypad_pkg::KEY_SUB: return calc_pkg::OP_SUB;
            keypad_pkg::KEY_MUL: return calc_pkg::OP_MUL;
            default:             return calc_pkg::OP_NONE;
        endcase
    endfunction

    assign fire   = key_req & ~key_ack;          // one decode per handshake
    assign kclass = key_class(key_word.idx);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_ack   <= 1'b0;
            digit_stb <= 1'b0;
            neg_stb   <= 1'b0;
            op_stb    <= 1'b0;
            eq_stb    <= 1'b0;
            clr_stb   <= 1'b0;
        end else begin
            key_ack   <= key_req;                // follows req one edge later
            digit_stb <= fire && (kclass == keypad_pkg::KC_DIGIT);
            neg_stb   <= fire && (kclass == keypad_pkg::KC_NEG);
            op_stb    <= fire && (kclass == keypad_pkg::KC_OP);
            eq_stb    <= fire && (kclass == keypad_pkg::KC_EQ);
            clr_stb   <= fire && (kclass == keypad_pkg::KC_CLR);
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            digit <= digit_value(key_word.idx);  // valid alongside digit_stb
            op    <= op_code(key_word.idx);      // valid alongside op_stb
        end
    end

endmodule

// File: hw/operand_entry.sv
`timescale 1ns/1ps

module operand_entry (
    input  logic                                clk,
    input  logic                                nRST,
    input  logic                                digit_stb,
    input  logic [3:0]                          digit,
    input  logic                                neg_stb,
    input  logic                                op_stb,
    input  logic                                eq_stb,
    input  logic                                clr_stb,
    output logic signed [calc_pkg::DATA_W-1:0]  operand
);

    logic [calc_pkg::ENTRY_W-1:0]        mag;        // decimal magnitude
    logic                                neg;        // entry sign
    logic [2:0]                          ndigits;
    logic signed [calc_pkg::DATA_W-1:0]  mag_ext;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            mag     <= '0;
            neg     <= 1'b0;
            ndigits <= 3'd0;
        end else if (op_stb || eq_stb || clr_stb) begin
            mag     <= '0;                       // accumulator samples on this edge
            neg     <= 1'b0;
            ndigits <= 3'd0;
        end else if (digit_stb) begin
            if (ndigits < 3'(calc_pkg::MAX_DIGITS)) begin
                mag     <= mag * calc_pkg::ENTRY_W'(10) +
                           {{(calc_pkg::ENTRY_W - 4){1'b0}}, digit};
                ndigits <= ndigits + 3'd1;
            end
            // extra digits dropped
        end else if (neg_stb) begin
            neg <= ~neg;
        end
    end

    assign mag_ext = {{(calc_pkg::DATA_W - calc_pkg::ENTRY_W){1'b0}}, mag};
    assign operand = neg ? -mag_ext : mag_ext;   // also the entry display value

endmodule

// File: hw/calc_accum.sv
`timescale 1ns/1ps

module calc_accum (
    input  logic                                clk,
    input  logic                                nRST,
    input  logic                                op_stb,
    input  calc_pkg::op_e                       op,
    input  logic                                eq_stb,
    input  logic                                clr_stb,
    input  logic signed [calc_pkg::DATA_W-1:0]  operand,
    output logic signed [calc_pkg::DATA_W-1:0]  result,
    output logic                                result_valid,
    output logic                                overflow
);

    calc_pkg::op_e                         pending;  // operator waiting for rhs
    logic signed [2*calc_pkg::DATA_W-1:0]  acc_ext;
    logic signed [2*calc_pkg::DATA_W-1:0]  opd_ext;
    logic signed [2*calc_pkg::DATA_W-1:0]  raw;      // unclipped, no wrap possible
    logic signed [2*calc_pkg::DATA_W-1:0]  clamped;
    logic                                  clip;

    assign acc_ext = {{calc_pkg::DATA_W{result[calc_pkg::DATA_W-1]}}, result};
    assign opd_ext = {{calc_pkg::DATA_W{operand[calc_pkg::DATA_W-1]}}, operand};

    always_comb begin
        case (pending)
            calc_pkg::OP_ADD: raw = acc_ext + opd_ext;
            calc_pkg::OP_SUB: raw = acc_ext - opd_ext;
            calc_pkg::OP_MUL: raw = acc_ext * opd_ext;
            default:          raw = opd_ext;         // nothing pending, load
        endcase

        clip    = 1'b1;
        clamped = raw;
        if (raw > calc_pkg::SAT_MAX)
            clamped = calc_pkg::SAT_MAX;
        else if (raw < calc_pkg::SAT_MIN)
            clamped = calc_pkg::SAT_MIN;
        else
            clip = 1'b0;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            result       <= '0;
            pending      <= calc_pkg::OP_NONE;
            result_valid <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (clr_stb) begin
                result   <= '0;
                pending  <= calc_pkg::OP_NONE;
                overflow <= 1'b0;
            end else if (op_stb || eq_stb) begin
                result <= clamped[calc_pkg::DATA_W-1:0];
                if (clip)
                    overflow <= 1'b1;            // sticky until clear
                if (eq_stb) begin
                    pending      <= calc_pkg::OP_NONE;
                    result_valid <= 1'b1;
                end else begin
                    pending <= op;               // strict left to right
                end
            end
        end
    end

endmodule

// File: hw/keypad_calc_top.sv
`timescale 1ns/1ps

module keypad_calc_top (
    input  logic                                clk,
    input  logic                                nRST,
    input  logic [3:0]                          row_in,
    output logic [3:0]                          col_out,
    output logic signed [calc_pkg::DATA_W-1:0]  entry_value,
    output logic signed [calc_pkg::DATA_W-1:0]  result,
    output logic                                result_valid,
    output logic                                overflow
);

    logic                  key_req;
    logic                  key_ack;
    keypad_pkg::key_pos_u  key_word;
    logic                  digit_stb;
    logic [3:0]            digit;
    logic                  neg_stb;
    logic                  op_stb;
    calc_pkg::op_e         op;
    logic                  eq_stb;
    logic                  clr_stb;

    keypad_scan u_scan (
        .clk      (clk),
        .nRST     (nRST),
        .row_in   (row_in),
        .col_out  (col_out),
        .key_req  (key_req),
        .key_word (key_word),
        .key_ack  (key_ack)
    );

    key_dispatch u_dispatch (
        .clk       (clk),
        .nRST      (nRST),
        .key_req   (key_req),
        .key_word  (key_word),
        .key_ack   (key_ack),
        .digit_stb (digit_stb),
        .digit     (digit),
        .neg_stb   (neg_stb),
        .op_stb    (op_stb),
        .op        (op),
        .eq_stb    (eq_stb),
        .clr_stb   (clr_stb)
    );

    operand_entry u_entry (
        .clk       (clk),
        .nRST      (nRST),
        .digit_stb (digit_stb),
        .digit     (digit),
        .neg_stb   (neg_stb),
        .op_stb    (op_stb),
        .eq_stb    (eq_stb),
        .clr_stb   (clr_stb),
        .operand   (entry_value)                 // entry shown as typed
    );

    calc_accum u_accum (
        .clk          (clk),
        .nRST         (nRST),
        .op_stb       (op_stb),
        .op           (op),
        .eq_stb       (eq_stb),
        .clr_stb      (clr_stb),
        .operand      (entry_value),
        .result       (result),
        .result_valid (result_valid),
        .overflow     (overflow)
    );

endmodule

// File: dv/keypad_calc_chk.sv
`timescale 1ns/1ps

module keypad_calc_chk (
    input logic       clk,
    input logic       nRST,
    input logic       key_req,
    input logic       key_ack,
    input logic [3:0] key_word,
    input logic [4:0] strobes,                       // digit, neg, op, eq, clr
    input logic [3:0] col_out
);

    int fail_cnt = 0;                                // failed assertions so far

    word_stable: assert property (@(posedge clk) disable iff (!nRST)
        key_req && $past(key_req) |-> $stable(key_word))
    else begin
        fail_cnt++;
        $error("key_word changed while key_req was high");
    end

    ack_after_req: assert property (@(posedge clk) disable iff (!nRST)
        $rose(key_ack) |-> key_req)
    else begin
        fail_cnt++;
        $error("key_ack rose without a pending key_req");
    end

    one_strobe: assert property (@(posedge clk) disable iff (!nRST)
        $onehot0(strobes))
    else begin
        fail_cnt++;
        $error("more than one command strobe in a cycle");
    end

    one_column: assert property (@(posedge clk) disable iff (!nRST)
        $onehot(~col_out))
    else begin
        fail_cnt++;
        $error("col_out does not drive exactly one column low");
    end

endmodule

// top level sees both the handshake and the keypad pins
bind keypad_calc_top keypad_calc_chk u_chk (
    .clk      (clk),
    .nRST     (nRST),
    .key_req  (key_req),
    .key_ack  (key_ack),
    .key_word (key_word),
    .strobes  ({digit_stb, neg_stb, op_stb, eq_stb, clr_stb}),
    .col_out  (col_out)
);

// File: dv/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic               clk,
    input  logic               nRST,
    input  logic signed [15:0] entry_value,
    input  logic signed [15:0] result,
    input  logic               result_valid,
    input  logic               overflow,
    input  logic signed [15:0] exp_entry,
    input  logic signed [15:0] exp_result,
    input  logic               exp_overflow,
    input  logic               check_now,        // key released, state settled
    input  int                 exp_valid,        // eq presses so far
    input  int                 assert_fails,
    input  logic               report_req,
    output logic               report_done,
    output int                 fail_total
);

    int err_cnt   = 0;
    int check_cnt = 0;
    int valid_cnt = 0;                           // result_valid pulses seen

    task automatic compare(input string name, input logic signed [31:0] got,
                           input logic signed [31:0] want);
        check_cnt++;
        if (got !== want) begin
            err_cnt++;
            $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    initial begin
        report_done = 1'b0;
        fail_total  = 0;
    end

    always @(posedge clk) begin
        if (nRST && result_valid) begin
            valid_cnt++;
            compare("result", result, exp_result);
            compare("overflow", overflow, exp_overflow);
        end
        if (nRST && check_now) begin
            compare("entry_value", entry_value, exp_entry);
            compare("result", result, exp_result);
            compare("overflow", overflow, exp_overflow);
        end
        if (report_req && !report_done) begin
            if (valid_cnt != exp_valid) begin
                err_cnt++;
                $display("result_valid pulsed %0d times but %0d pulses were expected",
                         valid_cnt, exp_valid);
            end
            fail_total = err_cnt + assert_fails;
            $display("closing: %0d checks, %0d errors, %0d assertion failures",
                     check_cnt, err_cnt, assert_fails);
            report_done = 1'b1;
        end
    end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int N_EXPR       = 30;                     // random expressions
    localparam int MAX_PRESSES  = 40 + N_EXPR * 19;       // directed plus worst random case
    localparam int WATCHDOG_CYC = MAX_PRESSES * 120 + 1000;

    logic               clk = 1'b0;
    logic               nRST;
    logic [3:0]         row_in;
    logic [3:0]         col_out;
    logic signed [15:0] entry_value;
    logic signed [15:0] result;
    logic               result_valid;
    logic               overflow;
    logic               key_down;                         // a switch is closed
    logic [3:0]         key_pos;                          // row in [3:2], col in [1:0]
    logic signed [15:0] exp_entry;
    logic signed [15:0] exp_result;
    logic               exp_overflow;
    logic               check_now;
    logic               report_req;
    logic               report_done;
    int                 exp_valid;
    int                 fail_total;
    int                 seq [0:63];                       // keys since the last clear
    int                 seq_len;

    always #2 clk = ~clk;

    // closed switch pulls its row low while its column is driven
    always_comb begin
        row_in = 4'hf;
        if (key_down && !col_out[key_pos[1:0]])
            row_in[key_pos[3:2]] = 1'b0;
    end

    keypad_calc_top dut (
        .clk          (clk),
        .nRST         (nRST),
        .row_in       (row_in),
        .col_out      (col_out),
        .entry_value  (entry_value),
        .result       (result),
        .result_valid (result_valid),
        .overflow     (overflow)
    );

    tb_checker chk (
        .clk          (clk),
        .nRST         (nRST),
        .entry_value  (entry_value),
        .result       (result),
        .result_valid (result_valid),
        .overflow     (overflow),
        .exp_entry    (exp_entry),
        .exp_result   (exp_result),
        .exp_overflow (exp_overflow),
        .check_now    (check_now),
        .exp_valid    (exp_valid),
        .assert_fails (dut.u_chk.fail_cnt),
        .report_req   (report_req),
        .report_done  (report_done),
        .fail_total   (fail_total)
    );

    function automatic int digit_pos(input int d);
        if (d == 0)
            return keypad_pkg::KEY_ZERO;
        return ((d - 1) / 3) * 4 + (d - 1) % 3;           // 1..9 fill the 3x3 block
    endfunction

    // expected {overflow, result, entry} after the first n keys of seq
    function automatic logic [32:0] ref_calc(input int n);
        int   mag;
        int   ndig;
        int   acc;
        int   pend;                                       // pending op key, -1 if none
        int   val;
        int   key;
        logic neg;
        logic ovf;
        logic is_op;
        mag  = 0;
        ndig = 0;
        acc  = 0;
        pend = -1;
        neg  = 1'b0;
        ovf  = 1'b0;
        for (int i = 0; i < n; i++) begin
            key   = seq[i];
            is_op = (key == keypad_pkg::KEY_ADD) || (key == keypad_pkg::KEY_SUB) ||
                    (key == keypad_pkg::KEY_MUL);
            if (key == keypad_pkg::KEY_NEG) begin
                neg = !neg;
            end else if (key == keypad_pkg::KEY_CLR) begin
                acc  = 0;
                pend = -1;
                ovf  = 1'b0;
            end else if (is_op || key == keypad_pkg::KEY_EQ) begin
                val = neg ? -mag : mag;
                case (pend)
                    keypad_pkg::KEY_ADD: val = acc + val;
                    keypad_pkg::KEY_SUB: val = acc - val;
                    keypad_pkg::KEY_MUL: val = acc * val;
                    default: ;                            // nothing pending, take entry
                endcase
                if (val > calc_pkg::SAT_MAX) begin
                    val = calc_pkg::SAT_MAX;
                    ovf = 1'b1;
                end else if (val < calc_pkg::SAT_MIN) begin
                    val = calc_pkg::SAT_MIN;
                    ovf = 1'b1;
                end
                acc  = val;
                pend = is_op ? key : -1;
            end else if (ndig < calc_pkg::MAX_DIGITS) begin
                for (int d = 0; d < 10; d++)
                    if (digit_pos(d) == key) val = d;
                mag  = mag * 10 + val;
                ndig = ndig + 1;
            end
            if (is_op || key == keypad_pkg::KEY_EQ || key == keypad_pkg::KEY_CLR) begin
                mag  = 0;                                 // entry restarts
                ndig = 0;
                neg  = 1'b0;
            end
        end
        val = neg ? -mag : mag;
        return {ovf, acc[15:0], val[15:0]};
    endfunction

    task automatic pulse_check();
        check_now = 1'b1;
        @(negedge clk);
        check_now = 1'b0;
    endtask

    // returns on the first falling edge after column c goes low
    task automatic wait_column(input int c);
        while (!col_out[c]) @(negedge clk);               // let a current dwell pass
        while (col_out[c]) @(negedge clk);
    endtask

    task automatic press_key(input int pos, input int hold);
        key_pos  = 4'(pos);
        key_down = 1'b1;
        repeat (hold) @(negedge clk);
        key_down = 1'b0;
        repeat (20 + $urandom % 21) @(negedge clk);       // release gap
        pulse_check();
    endtask

    // hold 0 picks a random 40..80 cycle press
    task automatic enter_key(input int pos, input int hold);
        seq[seq_len] = pos;
        seq_len      = seq_len + 1;
        {exp_overflow, exp_result, exp_entry} = ref_calc(seq_len);
        if (pos == keypad_pkg::KEY_EQ)
            exp_valid = exp_valid + 1;
        press_key(pos, (hold > 0) ? hold : 40 + $urandom % 41);
    endtask

    task automatic enter_number(input int value, input int ndig);
        int scale;
        scale = 1;
        repeat (ndig - 1) scale = scale * 10;
        for (int k = 0; k < ndig; k++) begin
            enter_key(digit_pos((value / scale) % 10), 0); // most significant first
            scale = scale / 10;
        end
    endtask

    task automatic new_calc();
        seq_len = 0;
        enter_key(keypad_pkg::KEY_CLR, 0);
    endtask

    initial begin
        int seed;
        int nops;
        int op_sel;
        nRST         = 1'b0;
        key_down     = 1'b0;
        key_pos      = 4'd0;
        check_now    = 1'b0;
        report_req   = 1'b0;
        exp_entry    = '0;
        exp_result   = '0;
        exp_overflow = 1'b0;
        exp_valid    = 0;
        seq_len      = 0;
        seed         = $urandom(20);
        repeat (8) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
        pulse_check();                                    // idle state after reset
        enter_number(12345, 5);                           // fifth digit dropped
        enter_key(keypad_pkg::KEY_NEG, 0);
        new_calc();
        enter_number(12, 2);
        enter_key(keypad_pkg::KEY_ADD, 0);
        enter_number(30, 2);
        enter_key(keypad_pkg::KEY_EQ, 0);
        enter_number(7, 1);
        enter_key(keypad_pkg::KEY_SUB, 0);
        enter_number(9, 1);
        enter_key(keypad_pkg::KEY_MUL, 0);
        enter_number(3, 1);
        enter_key(keypad_pkg::KEY_EQ, 0);                 // left to right gives -6
        new_calc();
        enter_number(9999, 4);
        enter_key(keypad_pkg::KEY_MUL, 0);
        enter_number(9999, 4);
        enter_key(keypad_pkg::KEY_EQ, 0);                 // clips at +32767
        enter_key(keypad_pkg::KEY_CLR, 0);
        wait_column(digit_pos(8) % 4);                    // press is seen by the scanner
        press_key(digit_pos(8), 5);                       // bounce, too short to accept
        enter_key(digit_pos(5), 300);                     // long hold, one digit
        for (int e = 0; e < N_EXPR; e++) begin
            new_calc();
            nops = 1 + $urandom % 3;
            for (int o = 0; o < nops; o++) begin
                if (o > 0) begin
                    op_sel = $urandom % 3;
                    enter_key((op_sel == 0) ? keypad_pkg::KEY_ADD :
                              (op_sel == 1) ? keypad_pkg::KEY_SUB : keypad_pkg::KEY_MUL, 0);
                end
                enter_number($urandom % 10000, 1 + $urandom % 4);
                if ($urandom % 4 == 0)
                    enter_key(keypad_pkg::KEY_NEG, 0);
            end
            enter_key(keypad_pkg::KEY_EQ, 0);
        end
        report_req = 1'b1;
        wait (report_done);
        if (fail_total == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("sim failed");
        $finish;
    end

endmodule

// File: tb.f
hw/keypad_pkg.sv
hw/calc_pkg.sv
hw/keypad_scan.sv
hw/key_dispatch.sv
hw/operand_entry.sv
hw/calc_accum.sv
hw/keypad_calc_top.sv
dv/keypad_calc_chk.sv
dv/tb_checker.sv
dv/tb_top.sv
